// File: include/vchess_cfg.svh
`ifndef VCHESS_CFG_SVH
`define VCHESS_CFG_SVH

`define CTRL_BOARD_WIDTH 256 // 64 squares x 4 bits
`define CTRL_SIDE_WIDTH 32 // 8 squares per word
`define CTRL_BOARD_WORDS 8
`define CTRL_MAX_POSITIONS 256
`define CTRL_HALF_MOVE_WIDTH 10
`define CTRL_EVAL_WIDTH 24
`define CTRL_AXI_ADDR_WIDTH 40
`define CTRL_AXI_DATA_WIDTH 32
`define CTRL_REG_INDEX_WIDTH 14
`define CTRL_REG_INDEX_LSB 2 // Word addressing
`define CTRL_AXI_RESP_OKAY 2'b00

`define REG_CONTROL 0
`define REG_MOVE_INDEX 1
`define REG_POS_FLAGS 2
`define REG_HALF_MOVE 3
`define REG_CAPTURE_MOVES 4
`define REG_NEW_BOARD_BASE 8 // Words 8 to 15
`define REG_MOVE_EVAL 134
`define REG_MOVE_COUNT 135
`define REG_INITIAL_EVAL 136
`define REG_MOVE_BOARD_BASE 172 // Words 172 to 179

`define CTRL_BIT_NEW_BOARD_VALID 0
`define CTRL_BIT_CLEAR_MOVES 1
`define CTRL_BIT_MOVES_READY 2
`define CTRL_BIT_MOVE_READY 3
`define CTRL_BIT_INITIAL_STALEMATE 4
`define CTRL_BIT_INITIAL_MATE 5
`define CTRL_BIT_AM_IDLE 7
`define CTRL_BIT_USE_RANDOM 30
`define CTRL_BIT_SOFT_RESET 31

`define CTRL_BIT_WHITE_TO_MOVE 8 // Position flags word
`define CTRL_CASTLE_LSB 4
`define CTRL_EP_COL_LSB 0
`define CTRL_BIT_CAPTURE_MOVES 0

`endif

// File: source/vchess_ctrl_pkg.sv
`include "vchess_cfg.svh"

package vchess_ctrl_pkg;

   // Board as seen by the move generator
   typedef logic [`CTRL_BOARD_WIDTH-1:0] board_t;
   typedef logic [`CTRL_SIDE_WIDTH-1:0] side_word_t;

   typedef logic [$clog2(`CTRL_MAX_POSITIONS)-1:0] move_index_t;
   typedef logic [`CTRL_HALF_MOVE_WIDTH-1:0] half_move_t;
   typedef logic signed [`CTRL_EVAL_WIDTH-1:0] eval_t;

   typedef logic [3:0] castle_mask_t; // KQkq rights
   typedef logic [3:0] ep_col_t;

   // Host bus side
   typedef logic [`CTRL_REG_INDEX_WIDTH-1:0] reg_index_t;
   typedef logic [`CTRL_AXI_ADDR_WIDTH-1:0] axi_addr_t;
   typedef logic [`CTRL_AXI_DATA_WIDTH-1:0] axi_data_t;

endpackage

// File: source/axil_write_port.sv
`include "vchess_cfg.svh"

module axil_write_port
(
   input  logic                          clk,
   input  logic                          rst_n,

   input  vchess_ctrl_pkg::axi_addr_t    awaddr,
   input  logic                          awvalid,
   output logic                          awready,

   input  vchess_ctrl_pkg::axi_data_t    wdata,
   input  logic                          wvalid,
   output logic                          wready,

   output logic [1:0]                    bresp,
   output logic                          bvalid,
   input  logic                          bready,

   output logic                          wr_valid,
   output vchess_ctrl_pkg::reg_index_t   wr_index,
   output vchess_ctrl_pkg::axi_data_t    wr_data
);
   import vchess_ctrl_pkg::*;

   logic aw_held;
   logic w_held;

   // Both channels stall until the response is taken
   assign awready = ~aw_held & ~bvalid;
   assign wready = ~w_held & ~bvalid;
   assign bresp = `CTRL_AXI_RESP_OKAY;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         aw_held <= 1'b0;
         w_held <= 1'b0;
         wr_valid <= 1'b0;
         bvalid <= 1'b0;
      end
      else
      begin
         if (awvalid && awready)
            aw_held <= 1'b1;
         if (wvalid && wready)
            w_held <= 1'b1;

         // Single strobe once address and data are both in
         wr_valid <= aw_held & w_held & ~wr_valid & ~bvalid;

         if (wr_valid)
            bvalid <= 1'b1;
         else if (bvalid && bready)
         begin
            bvalid <= 1'b0;
            aw_held <= 1'b0; // Reopen both channels
            w_held <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
         wr_index <= awaddr[`CTRL_REG_INDEX_LSB +: `CTRL_REG_INDEX_WIDTH];
      if (wvalid && wready)
         wr_data <= wdata;
   end

endmodule

// File: source/axil_read_port.sv
`include "vchess_cfg.svh"

module axil_read_port
(
   input  logic                          clk,
   input  logic                          rst_n,

   input  vchess_ctrl_pkg::axi_addr_t    araddr,
   input  logic                          arvalid,
   output logic                          arready,

   output logic                          rvalid,
   output logic [1:0]                    rresp,
   input  logic                          rready,

   output logic                          rd_en,
   output vchess_ctrl_pkg::reg_index_t   rd_index
);
   import vchess_ctrl_pkg::*;

   assign arready = 1'b1; // Never stalls
   assign rresp = `CTRL_AXI_RESP_OKAY;

   assign rd_en = arvalid;
   assign rd_index = araddr[`CTRL_REG_INDEX_LSB +: `CTRL_REG_INDEX_WIDTH];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rvalid <= 1'b0;
      else if (arvalid)
         rvalid <= 1'b1; // New read wins over rready
      else if (rready)
         rvalid <= 1'b0;
   end

endmodule

// File: source/ctrl_reg_bank.sv
`include "vchess_cfg.svh"

module ctrl_reg_bank
(
   input  logic                             clk,
   input  logic                             rst_n,

   input  logic                             wr_valid,
   input  vchess_ctrl_pkg::reg_index_t      wr_index,
   input  vchess_ctrl_pkg::axi_data_t       wr_data,
   input  logic                             rd_en,
   input  vchess_ctrl_pkg::reg_index_t      rd_index,

   input  logic                             am_idle,
   input  logic                             am_moves_ready,
   input  logic                             am_move_ready,
   input  logic                             initial_mate,
   input  logic                             initial_stalemate,
   input  vchess_ctrl_pkg::move_index_t     am_move_count,
   input  vchess_ctrl_pkg::eval_t           am_eval,
   input  vchess_ctrl_pkg::eval_t           initial_eval,
   input  vchess_ctrl_pkg::board_t          move_board,

   output vchess_ctrl_pkg::axi_data_t       rdata,
   output logic                             new_board_valid,
   output logic                             clear_moves,
   output logic                             capture_moves,
   output logic                             use_random_bit,
   output logic                             soft_reset,
   output vchess_ctrl_pkg::move_index_t     move_index,
   output logic                             white_to_move,
   output vchess_ctrl_pkg::castle_mask_t    castle_mask,
   output vchess_ctrl_pkg::ep_col_t         en_passant_col,
   output vchess_ctrl_pkg::half_move_t      half_move,
   output vchess_ctrl_pkg::board_t          new_board
);
   import vchess_ctrl_pkg::*;

   localparam int WORD_SEL_WIDTH = $clog2(`CTRL_BOARD_WORDS);

   reg_index_t wr_board_off;
   reg_index_t rd_new_off;
   reg_index_t rd_move_off;
   axi_data_t  rd_word;

   // Offsets below the base wrap high and miss the window
   assign wr_board_off = wr_index - reg_index_t'(`REG_NEW_BOARD_BASE);
   assign rd_new_off = rd_index - reg_index_t'(`REG_NEW_BOARD_BASE);
   assign rd_move_off = rd_index - reg_index_t'(`REG_MOVE_BOARD_BASE);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         new_board_valid <= 1'b0;
         clear_moves <= 1'b0;
         use_random_bit <= 1'b0;
         soft_reset <= 1'b0;
         capture_moves <= 1'b0;
         move_index <= '0;
         white_to_move <= 1'b0;
         castle_mask <= '0;
         en_passant_col <= '0;
         half_move <= '0;
         new_board <= '0;
      end
      else if (wr_valid)
      begin
         case (wr_index)
            `REG_CONTROL:
            begin
               new_board_valid <= wr_data[`CTRL_BIT_NEW_BOARD_VALID];
               clear_moves <= wr_data[`CTRL_BIT_CLEAR_MOVES];
               use_random_bit <= wr_data[`CTRL_BIT_USE_RANDOM];
               soft_reset <= wr_data[`CTRL_BIT_SOFT_RESET];
            end
            `REG_MOVE_INDEX: move_index <= wr_data[$bits(move_index_t)-1:0];
            `REG_POS_FLAGS:
            begin
               white_to_move <= wr_data[`CTRL_BIT_WHITE_TO_MOVE];
               castle_mask <= wr_data[`CTRL_CASTLE_LSB +: $bits(castle_mask_t)];
               en_passant_col <= wr_data[`CTRL_EP_COL_LSB +: $bits(ep_col_t)];
            end
            `REG_HALF_MOVE: half_move <= wr_data[`CTRL_HALF_MOVE_WIDTH-1:0];
            `REG_CAPTURE_MOVES: capture_moves <= wr_data[`CTRL_BIT_CAPTURE_MOVES];
            default:
            begin
               // Board words; anything else is read-only or unmapped
               if (wr_board_off < `CTRL_BOARD_WORDS)
                  new_board[wr_board_off[WORD_SEL_WIDTH-1:0] * `CTRL_SIDE_WIDTH
                            +: `CTRL_SIDE_WIDTH] <= wr_data[`CTRL_SIDE_WIDTH-1:0];
            end
         endcase
      end
   end

   always_comb
   begin
      rd_word = '0;
      case (rd_index)
         `REG_CONTROL:
         begin
            rd_word[`CTRL_BIT_NEW_BOARD_VALID] = new_board_valid;
            rd_word[`CTRL_BIT_CLEAR_MOVES] = clear_moves;
            rd_word[`CTRL_BIT_MOVES_READY] = am_moves_ready;
            rd_word[`CTRL_BIT_MOVE_READY] = am_move_ready;
            rd_word[`CTRL_BIT_INITIAL_STALEMATE] = initial_stalemate;
            rd_word[`CTRL_BIT_INITIAL_MATE] = initial_mate;
            rd_word[`CTRL_BIT_AM_IDLE] = am_idle;
            rd_word[`CTRL_BIT_USE_RANDOM] = use_random_bit;
            rd_word[`CTRL_BIT_SOFT_RESET] = soft_reset;
         end
         `REG_MOVE_INDEX: rd_word = axi_data_t'(move_index);
         `REG_POS_FLAGS:
         begin
            rd_word[`CTRL_BIT_WHITE_TO_MOVE] = white_to_move;
            rd_word[`CTRL_CASTLE_LSB +: $bits(castle_mask_t)] = castle_mask;
            rd_word[`CTRL_EP_COL_LSB +: $bits(ep_col_t)] = en_passant_col;
         end
         `REG_HALF_MOVE: rd_word = axi_data_t'(half_move);
         `REG_CAPTURE_MOVES: rd_word[`CTRL_BIT_CAPTURE_MOVES] = capture_moves;
         `REG_MOVE_EVAL:
            rd_word = {{(`CTRL_AXI_DATA_WIDTH-`CTRL_EVAL_WIDTH){am_eval[`CTRL_EVAL_WIDTH-1]}},
                       am_eval};
         `REG_MOVE_COUNT: rd_word = axi_data_t'(am_move_count);
         `REG_INITIAL_EVAL:
            rd_word = {{(`CTRL_AXI_DATA_WIDTH-`CTRL_EVAL_WIDTH){initial_eval[`CTRL_EVAL_WIDTH-1]}},
                       initial_eval};
         default:
         begin
            if (rd_new_off < `CTRL_BOARD_WORDS)
               rd_word = new_board[rd_new_off[WORD_SEL_WIDTH-1:0] * `CTRL_SIDE_WIDTH
                                   +: `CTRL_SIDE_WIDTH];
            else if (rd_move_off < `CTRL_BOARD_WORDS)
               rd_word = move_board[rd_move_off[WORD_SEL_WIDTH-1:0] * `CTRL_SIDE_WIDTH
                                    +: `CTRL_SIDE_WIDTH];
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rdata <= '0;
      else if (rd_en)
         rdata <= rd_word; // Lands with rvalid
   end

endmodule

// File: source/engine_ctrl.sv
module engine_ctrl
(
   input  logic                             clk,
   input  logic                             rst_n,

   input  vchess_ctrl_pkg::axi_addr_t       awaddr,
   input  logic                             awvalid,
   output logic                             awready,
   input  vchess_ctrl_pkg::axi_data_t       wdata,
   input  logic                             wvalid,
   output logic                             wready,
   output logic [1:0]                       bresp,
   output logic                             bvalid,
   input  logic                             bready,
   input  vchess_ctrl_pkg::axi_addr_t       araddr,
   input  logic                             arvalid,
   output logic                             arready,
   output vchess_ctrl_pkg::axi_data_t       rdata,
   output logic [1:0]                       rresp,
   output logic                             rvalid,
   input  logic                             rready,

   input  logic                             am_idle,
   input  logic                             am_moves_ready,
   input  logic                             am_move_ready,
   input  logic                             initial_mate,
   input  logic                             initial_stalemate,
   input  vchess_ctrl_pkg::move_index_t     am_move_count,
   input  vchess_ctrl_pkg::eval_t           am_eval,
   input  vchess_ctrl_pkg::eval_t           initial_eval,
   input  vchess_ctrl_pkg::board_t          move_board,

   output logic                             new_board_valid,
   output logic                             clear_moves,
   output logic                             capture_moves,
   output logic                             use_random_bit,
   output logic                             soft_reset,
   output vchess_ctrl_pkg::move_index_t     move_index,
   output logic                             white_to_move,
   output vchess_ctrl_pkg::castle_mask_t    castle_mask,
   output vchess_ctrl_pkg::ep_col_t         en_passant_col,
   output vchess_ctrl_pkg::half_move_t      half_move,
   output vchess_ctrl_pkg::board_t          new_board
);
   import vchess_ctrl_pkg::*;

   logic       wr_valid;
   reg_index_t wr_index;
   axi_data_t  wr_data;
   logic       rd_en;
   reg_index_t rd_index;

   axil_write_port i_axil_write_port
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .wready   (wready),
      .bresp    (bresp),
      .bvalid   (bvalid),
      .bready   (bready),
      .wr_valid (wr_valid),
      .wr_index (wr_index),
      .wr_data  (wr_data)
   );

   axil_read_port i_axil_read_port
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .araddr   (araddr),
      .arvalid  (arvalid),
      .arready  (arready),
      .rvalid   (rvalid),
      .rresp    (rresp),
      .rready   (rready),
      .rd_en    (rd_en),
      .rd_index (rd_index)
   );

   ctrl_reg_bank i_ctrl_reg_bank
   (
      .clk               (clk),
      .rst_n             (rst_n),
      .wr_valid          (wr_valid),
      .wr_index          (wr_index),
      .wr_data           (wr_data),
      .rd_en             (rd_en),
      .rd_index          (rd_index),
      .am_idle           (am_idle),
      .am_moves_ready    (am_moves_ready),
      .am_move_ready     (am_move_ready),
      .initial_mate      (initial_mate),
      .initial_stalemate (initial_stalemate),
      .am_move_count     (am_move_count),
      .am_eval           (am_eval),
      .initial_eval      (initial_eval),
      .move_board        (move_board),
      .rdata             (rdata),
      .new_board_valid   (new_board_valid),
      .clear_moves       (clear_moves),
      .capture_moves     (capture_moves),
      .use_random_bit    (use_random_bit),
      .soft_reset        (soft_reset),
      .move_index        (move_index),
      .white_to_move     (white_to_move),
      .castle_mask       (castle_mask),
      .en_passant_col    (en_passant_col),
      .half_move         (half_move),
      .new_board         (new_board)
   );

endmodule

// File: verification/engine_ctrl_tb.sv
`include "vchess_cfg.svh"

module engine_ctrl_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import vchess_ctrl_pkg::*;

   localparam logic [1:0] OP_WRITE = 2'd0;
   localparam logic [1:0] OP_READ = 2'd1;
   localparam logic [1:0] OP_IGNORED = 2'd2; // Write that must change nothing
   localparam int MOVE_EVAL_VAL = -1234;
   localparam int INITIAL_EVAL_VAL = 5678;
   localparam int MOVE_COUNT_VAL = 201;
   localparam axi_data_t CTRL_MASK = (32'd1 << `CTRL_BIT_NEW_BOARD_VALID)
      | (32'd1 << `CTRL_BIT_CLEAR_MOVES) | (32'd1 << `CTRL_BIT_USE_RANDOM)
      | (32'd1 << `CTRL_BIT_SOFT_RESET);
   // Engine held idle with moves ready in a stalemate position
   localparam axi_data_t STATUS_WORD = (32'd1 << `CTRL_BIT_MOVES_READY)
      | (32'd1 << `CTRL_BIT_INITIAL_STALEMATE) | (32'd1 << `CTRL_BIT_AM_IDLE);

   typedef struct packed
   {
      logic [1:0] op;
      reg_index_t index;
      axi_data_t  data;
      axi_data_t  expected; // Read value, or output word after a write
   } entry_t;

   entry_t     stim_table[$];
   logic       table_ready;
   axi_data_t  lcg_state;

   logic clk, rst_n;
   axi_addr_t awaddr, araddr;
   axi_data_t wdata, rdata;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [1:0] bresp, rresp;
   logic am_idle, am_moves_ready, am_move_ready, initial_mate, initial_stalemate;
   move_index_t am_move_count, move_index;
   eval_t am_eval, initial_eval;
   board_t move_board, new_board;
   logic new_board_valid, clear_moves, capture_moves, use_random_bit, soft_reset;
   logic white_to_move;
   castle_mask_t castle_mask;
   ep_col_t en_passant_col;
   half_move_t half_move;

   engine_ctrl i_engine_ctrl (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic axi_data_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic axi_data_t move_word(input int k);
      return axi_data_t'(32'h5A00_0000 + k * 32'h0011_2233);
   endfunction

   // Output fields that a write to idx should drive, packed as in the register
   function automatic axi_data_t observed_output(input reg_index_t idx);
      axi_data_t word;
      int off;
      word = '0;
      off = int'(idx) - `REG_NEW_BOARD_BASE;
      if (idx == `REG_CONTROL)
      begin
         word[`CTRL_BIT_NEW_BOARD_VALID] = new_board_valid;
         word[`CTRL_BIT_CLEAR_MOVES] = clear_moves;
         word[`CTRL_BIT_USE_RANDOM] = use_random_bit;
         word[`CTRL_BIT_SOFT_RESET] = soft_reset;
      end
      else if (idx == `REG_MOVE_INDEX)
         word = 32'(move_index);
      else if (idx == `REG_POS_FLAGS)
      begin
         word[`CTRL_BIT_WHITE_TO_MOVE] = white_to_move;
         word[7:4] = castle_mask;
         word[3:0] = en_passant_col;
      end
      else if (idx == `REG_HALF_MOVE)
         word = 32'(half_move);
      else if (idx == `REG_CAPTURE_MOVES)
         word[0] = capture_moves;
      else if (off >= 0 && off < `CTRL_BOARD_WORDS)
         word = new_board[off * 32 +: 32];
      return word;
   endfunction

   task automatic check_value(input axi_data_t got, input axi_data_t exp, input string what);
      if (got !== exp)
      begin
         $display("FAIL at %0d ns: %s, got %08h expected %08h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic add_entry(input logic [1:0] op, input int idx, input axi_data_t data,
                            input axi_data_t exp);
      entry_t e;
      e.op = op;
      e.index = reg_index_t'(idx);
      e.data = data;
      e.expected = exp;
      stim_table.push_back(e);
   endtask

   task automatic build_table();
      int field_idx [4];
      axi_data_t field_mask [4];
      axi_data_t last_field [4];
      axi_data_t board_words [8];
      axi_data_t last_ctrl;
      axi_data_t d;
      field_idx = '{`REG_MOVE_INDEX, `REG_HALF_MOVE, `REG_CAPTURE_MOVES, `REG_POS_FLAGS};
      field_mask = '{32'h0000_00FF, 32'h0000_03FF, 32'h0000_0001, 32'h0000_01FF};
      add_entry(OP_READ, `REG_CONTROL, 32'd0, STATUS_WORD); // Reset values
      for (int f = 0; f < 4; f++)
         add_entry(OP_READ, field_idx[f], 32'd0, 32'd0);
      for (int k = 0; k < `CTRL_BOARD_WORDS; k++)
         add_entry(OP_READ, `REG_NEW_BOARD_BASE + k, 32'd0, 32'd0);
      last_ctrl = '0;
      repeat (3)
      begin
         d = lcg_next();
         last_ctrl = d & CTRL_MASK;
         add_entry(OP_WRITE, `REG_CONTROL, d, last_ctrl);
         add_entry(OP_READ, `REG_CONTROL, 32'd0, last_ctrl | STATUS_WORD);
      end
      for (int f = 0; f < 4; f++)
      begin
         last_field[f] = '0;
         repeat (2)
         begin
            d = lcg_next();
            last_field[f] = d & field_mask[f];
            add_entry(OP_WRITE, field_idx[f], d, last_field[f]);
            add_entry(OP_READ, field_idx[f], 32'd0, last_field[f]);
         end
      end
      for (int k = 0; k < `CTRL_BOARD_WORDS; k++)
      begin
         board_words[k] = lcg_next();
         add_entry(OP_WRITE, `REG_NEW_BOARD_BASE + k, board_words[k], board_words[k]);
      end
      for (int k = 0; k < `CTRL_BOARD_WORDS; k++)
         add_entry(OP_READ, `REG_NEW_BOARD_BASE + k, 32'd0, board_words[k]);
      add_entry(OP_READ, `REG_MOVE_EVAL, 32'd0, axi_data_t'(MOVE_EVAL_VAL));
      add_entry(OP_READ, `REG_MOVE_COUNT, 32'd0, axi_data_t'(MOVE_COUNT_VAL));
      add_entry(OP_READ, `REG_INITIAL_EVAL, 32'd0, axi_data_t'(INITIAL_EVAL_VAL));
      for (int k = 0; k < `CTRL_BOARD_WORDS; k++)
         add_entry(OP_READ, `REG_MOVE_BOARD_BASE + k, 32'd0, move_word(k));
      add_entry(OP_READ, 5, 32'd0, 32'd0); // Unmapped
      add_entry(OP_READ, 137, 32'd0, 32'd0);
      add_entry(OP_READ, 180, 32'd0, 32'd0);
      add_entry(OP_READ, 1000, 32'd0, 32'd0);
      add_entry(OP_IGNORED, 6, lcg_next(), 32'd0);
      add_entry(OP_IGNORED, `REG_MOVE_EVAL, lcg_next(), 32'd0);
      add_entry(OP_IGNORED, `REG_MOVE_BOARD_BASE + 3, lcg_next(), 32'd0);
      add_entry(OP_IGNORED, `REG_NEW_BOARD_BASE + `CTRL_BOARD_WORDS, lcg_next(), 32'd0);
      add_entry(OP_READ, `REG_CONTROL, 32'd0, last_ctrl | STATUS_WORD);
      for (int f = 0; f < 4; f++)
         add_entry(OP_READ, field_idx[f], 32'd0, last_field[f]);
      for (int k = 0; k < `CTRL_BOARD_WORDS; k++)
         add_entry(OP_READ, `REG_NEW_BOARD_BASE + k, 32'd0, board_words[k]);
   endtask

   // Handshakes are sampled mid-cycle and take effect on the next rising edge
   task automatic write_reg(input reg_index_t idx, input axi_data_t data);
      logic aw_hit;
      logic w_hit;
      logic b_hit;
      awaddr = axi_addr_t'({idx, 2'b00});
      awvalid = 1'b1;
      wdata = data;
      wvalid = 1'b1;
      bready = 1'b1;
      while (awvalid || wvalid)
      begin
         @(negedge clk);
         aw_hit = awvalid & awready;
         w_hit = wvalid & wready;
         @(posedge clk);
         #2;
         if (aw_hit)
            awvalid = 1'b0;
         if (w_hit)
            wvalid = 1'b0;
      end
      b_hit = 1'b0;
      while (!b_hit)
      begin
         @(negedge clk);
         b_hit = bvalid;
         if (b_hit)
            check_value(32'(bresp), 32'd0, "write response code");
         @(posedge clk);
         #2;
      end
      bready = 1'b0;
   endtask

   task automatic read_reg(input reg_index_t idx, output axi_data_t data);
      logic ar_hit;
      logic r_hit;
      araddr = axi_addr_t'({idx, 2'b00});
      arvalid = 1'b1;
      rready = 1'b1;
      ar_hit = 1'b0;
      while (!ar_hit)
      begin
         @(negedge clk);
         ar_hit = arvalid & arready;
         @(posedge clk);
         #2;
      end
      arvalid = 1'b0;
      r_hit = 1'b0;
      data = '0;
      while (!r_hit)
      begin
         @(negedge clk);
         r_hit = rvalid;
         data = rdata;
         if (r_hit)
            check_value(32'(rresp), 32'd0, "read response code");
         @(posedge clk);
         #2;
      end
      rready = 1'b0;
   endtask

   initial
   begin
      entry_t e;
      axi_data_t got;
      axi_data_t reg_model [`REG_NEW_BOARD_BASE + `CTRL_BOARD_WORDS]; // Writable registers
      lcg_state = 32'd63;
      table_ready = 1'b0;
      rst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      am_idle = 1'b1;
      am_moves_ready = 1'b1;
      am_move_ready = 1'b0;
      initial_mate = 1'b0;
      initial_stalemate = 1'b1;
      am_move_count = move_index_t'(MOVE_COUNT_VAL);
      am_eval = eval_t'(MOVE_EVAL_VAL);
      initial_eval = eval_t'(INITIAL_EVAL_VAL);
      for (int k = 0; k < `CTRL_BOARD_WORDS; k++)
         move_board[k * 32 +: 32] = move_word(k);
      for (int j = 0; j < `REG_NEW_BOARD_BASE + `CTRL_BOARD_WORDS; j++)
         reg_model[j] = '0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int j = 0; j < `REG_NEW_BOARD_BASE + `CTRL_BOARD_WORDS; j++)
         check_value(observed_output(reg_index_t'(j)), reg_model[j],
                     "control outputs after reset");
      check_value(32'({arready, awready, wready, bvalid, rvalid}), 32'b11100,
                  "handshakes after reset");
      foreach (stim_table[i])
      begin
         e = stim_table[i];
         if (e.op == OP_READ)
         begin
            read_reg(e.index, got);
            check_value(got, e.expected, $sformatf("read of register %0d", e.index));
         end
         else if (e.op == OP_WRITE)
         begin
            write_reg(e.index, e.data);
            check_value(observed_output(e.index), e.expected,
                        $sformatf("outputs after write to register %0d", e.index));
            reg_model[int'(e.index)] = e.expected;
         end
         else
         begin
            write_reg(e.index, e.data);
            for (int j = 0; j < `REG_NEW_BOARD_BASE + `CTRL_BOARD_WORDS; j++)
               check_value(observed_output(reg_index_t'(j)), reg_model[j],
                           $sformatf("outputs after ignored write to %0d", e.index));
         end
      end
      $display("** PASS **");
      $finish;
   end

   initial
   begin
      wait (table_ready === 1'b1);
      repeat (stim_table.size() * 20 + 20) @(posedge clk);
      $display("Timeout: the test did not finish within %0d clock cycles",
               stim_table.size() * 20 + 20);
      $display("** FAIL **");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: engine_ctrl.f
+incdir+include
source/vchess_ctrl_pkg.sv
source/axil_write_port.sv
source/axil_read_port.sv
source/ctrl_reg_bank.sv
source/engine_ctrl.sv
verification/engine_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the engine_ctrl testbench with Verilator and runs it.
# The simulator exits non-zero on any failure, which set -e passes on.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing -j 0 \
   -f engine_ctrl.f \
   --top-module engine_ctrl_tb \
   -o engine_ctrl_sim

./obj_dir/engine_ctrl_sim
